/* include/dram_defines.svh */
`ifndef DRAM_DEFINES_SVH
`define DRAM_DEFINES_SVH

// channel address fields, in bits
`define DRAM_BG_W 1
`define DRAM_BA_W 1
`define DRAM_RO_W 4
`define DRAM_CO_W 3
`define DRAM_OFS_W 2

// full byte address of one channel
`define DRAM_ADDR_W (`DRAM_BG_W + `DRAM_BA_W + `DRAM_RO_W + `DRAM_CO_W + `DRAM_OFS_W)

// one block is one word, so the byte offset drops out
`define DRAM_WORD_ADDR_W (`DRAM_ADDR_W - `DRAM_OFS_W)

`define DRAM_DATA_W 32

// request buffer between producer and consumer
`define REQ_FIFO_DEPTH 4

`endif

/* design/dram_pkg.sv */
`default_nettype none

`include "dram_defines.svh"

package dram_pkg;

  typedef enum logic {
    DRAM_READ  = 1'b0,
    DRAM_WRITE = 1'b1
  } dram_op_e;

  // field order as the vcache produces it
  typedef struct packed {
    logic [`DRAM_BG_W-1:0]  bg;
    logic [`DRAM_BA_W-1:0]  ba;
    logic [`DRAM_RO_W-1:0]  ro;
    logic [`DRAM_CO_W-1:0]  co;
    logic [`DRAM_OFS_W-1:0] byte_offset;
  } cache_ch_addr_s;

  // field order the dram channel expects, row on top
  typedef struct packed {
    logic [`DRAM_RO_W-1:0]  ro;
    logic [`DRAM_BG_W-1:0]  bg;
    logic [`DRAM_BA_W-1:0]  ba;
    logic [`DRAM_CO_W-1:0]  co;
    logic [`DRAM_OFS_W-1:0] byte_offset;
  } dram_ch_addr_s;

  // consumer fsm
  typedef enum logic [1:0] {
    MEM_IDLE = 2'd0,
    MEM_READ = 2'd1,
    MEM_RESP = 2'd2
  } mem_state_e;

endpackage

`default_nettype wire

/* design/dma_to_dram_req.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dram_defines.svh"

module dma_to_dram_req (
  input wire logic clk_i
  , input wire logic arst_n_i

  , input wire logic                     dma_pkt_v_i
  , input wire dram_pkg::dram_op_e       dma_pkt_op_i
  , input wire dram_pkg::cache_ch_addr_s dma_pkt_addr_i
  , input wire logic [`DRAM_DATA_W-1:0]  dma_pkt_data_i
  , output logic                         dma_pkt_yumi_o

  , output logic                         req_v_o
  , output dram_pkg::dram_op_e           req_op_o
  , output dram_pkg::dram_ch_addr_s      req_addr_o
  , output logic [`DRAM_DATA_W-1:0]      req_data_o
  , input wire logic                     req_ready_i
);

  import dram_pkg::*;

  dram_ch_addr_s dram_addr;
  logic          slot_free;

  // cache order to dram order
  assign dram_addr.ro          = dma_pkt_addr_i.ro;
  assign dram_addr.bg          = dma_pkt_addr_i.bg;
  assign dram_addr.ba          = dma_pkt_addr_i.ba;
  assign dram_addr.co          = dma_pkt_addr_i.co;
  assign dram_addr.byte_offset = dma_pkt_addr_i.byte_offset;

  // slot empties in the same cycle the fifo takes it
  assign slot_free      = ~req_v_o | req_ready_i;
  assign dma_pkt_yumi_o = dma_pkt_v_i & slot_free;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_v_o <= 1'b0;
    end else if (slot_free) begin
      req_v_o <= dma_pkt_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dma_pkt_yumi_o) begin
      req_op_o   <= dma_pkt_op_i;
      req_addr_o <= dram_addr;
      req_data_o <= dma_pkt_data_i;
    end
  end

  // yumi only while a packet is offered
  yumi_needs_valid: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    dma_pkt_yumi_o |-> dma_pkt_v_i
  ) else $error("yumi without valid");

endmodule

`default_nettype wire

/* design/dram_req_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dram_defines.svh"

module dram_req_fifo (
  input wire logic clk_i
  , input wire logic arst_n_i

  , input wire logic                    enq_v_i
  , input wire dram_pkg::dram_op_e      enq_op_i
  , input wire dram_pkg::dram_ch_addr_s enq_addr_i
  , input wire logic [`DRAM_DATA_W-1:0] enq_data_i
  , output logic                        enq_ready_o

  , output logic                        deq_v_o
  , output dram_pkg::dram_op_e          deq_op_o
  , output dram_pkg::dram_ch_addr_s     deq_addr_o
  , output logic [`DRAM_DATA_W-1:0]     deq_data_o
  , input wire logic                    deq_i
);

  import dram_pkg::*;

  localparam int PTR_W = $clog2(`REQ_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`REQ_FIFO_DEPTH + 1);

  dram_op_e               op_mem   [`REQ_FIFO_DEPTH];
  dram_ch_addr_s          addr_mem [`REQ_FIFO_DEPTH];
  logic [`DRAM_DATA_W-1:0] data_mem [`REQ_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_enq;
  logic             do_deq;

  assign enq_ready_o = (count != CNT_W'(`REQ_FIFO_DEPTH));
  assign deq_v_o     = (count != '0);
  assign do_enq      = enq_v_i & enq_ready_o;
  assign do_deq      = deq_i & deq_v_o;

  // head is read straight out of storage
  assign deq_op_o   = op_mem[rd_ptr];
  assign deq_addr_o = addr_mem[rd_ptr];
  assign deq_data_o = data_mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (do_enq) begin
      op_mem[wr_ptr]   <= enq_op_i;
      addr_mem[wr_ptr] <= enq_addr_i;
      data_mem[wr_ptr] <= enq_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= (wr_ptr == PTR_W'(`REQ_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_deq) begin
        rd_ptr <= (rd_ptr == PTR_W'(`REQ_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // producer keeps offering while full, nothing is dropped
  no_enq_full: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    enq_v_i && !enq_ready_o |=> enq_v_i
  ) else $error("request withdrawn while fifo was full");

  no_deq_empty: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    deq_i |-> deq_v_o
  ) else $error("dequeue from empty fifo");

endmodule

`default_nettype wire

/* design/dram_channel_mem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dram_defines.svh"

module dram_channel_mem (
  input wire logic clk_i
  , input wire logic arst_n_i

  , input wire logic                    req_v_i
  , input wire dram_pkg::dram_op_e      req_op_i
  , input wire dram_pkg::dram_ch_addr_s req_addr_i
  , input wire logic [`DRAM_DATA_W-1:0] req_data_i
  , output logic                        req_deq_o

  , output logic                        rdata_v_o
  , output logic [`DRAM_DATA_W-1:0]     rdata_o
  , output dram_pkg::cache_ch_addr_s    rdone_addr_o
  , input wire logic                    rdata_yumi_i
);

  import dram_pkg::*;

  localparam int MEM_WORDS = 1 << `DRAM_WORD_ADDR_W;

  logic [`DRAM_DATA_W-1:0] mem_r [MEM_WORDS];

  mem_state_e                  state_r;
  mem_state_e                  state_n;
  dram_ch_addr_s               rd_addr_r;
  logic [`DRAM_DATA_W-1:0]     rdata_r;
  logic [`DRAM_WORD_ADDR_W-1:0] req_word;
  logic [`DRAM_WORD_ADDR_W-1:0] rd_word;
  logic                        wr_en;
  logic                        rd_start;

  // word index in dram order, byte offset dropped
  assign req_word = {req_addr_i.ro, req_addr_i.bg, req_addr_i.ba, req_addr_i.co};
  assign rd_word  = {rd_addr_r.ro, rd_addr_r.bg, rd_addr_r.ba, rd_addr_r.co};

  // only take a new request when idle
  assign req_deq_o = (state_r == MEM_IDLE) & req_v_i;
  assign wr_en     = req_deq_o & (req_op_i == DRAM_WRITE);
  assign rd_start  = req_deq_o & (req_op_i == DRAM_READ);

  always_comb begin
    state_n = state_r;
    case (state_r)
      MEM_IDLE: begin
        if (rd_start) begin
          state_n = MEM_READ;
        end
      end
      MEM_READ: state_n = MEM_RESP;
      MEM_RESP: begin
        if (rdata_yumi_i) begin
          state_n = MEM_IDLE;
        end
      end
      default: state_n = MEM_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= MEM_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_r[req_word] <= req_data_i;
    end
    if (rd_start) begin
      rd_addr_r <= req_addr_i;
    end
    if (state_r == MEM_READ) begin
      rdata_r <= mem_r[rd_word];
    end
  end

  assign rdata_v_o = (state_r == MEM_RESP);
  assign rdata_o   = rdata_r;

  // read-done address goes back in cache order
  assign rdone_addr_o.bg          = rd_addr_r.bg;
  assign rdone_addr_o.ba          = rd_addr_r.ba;
  assign rdone_addr_o.ro          = rd_addr_r.ro;
  assign rdone_addr_o.co          = rd_addr_r.co;
  assign rdone_addr_o.byte_offset = rd_addr_r.byte_offset;

  resp_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    rdata_v_o && !rdata_yumi_i |=> rdata_v_o && $stable(rdata_o) && $stable(rdone_addr_o)
  ) else $error("read response changed before yumi");

endmodule

`default_nettype wire

/* design/cache_dma_test_dram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dram_defines.svh"

module cache_dma_test_dram (
  input wire logic clk_i
  , input wire logic arst_n_i

  , input wire logic                     dma_pkt_v_i
  , input wire dram_pkg::dram_op_e       dma_pkt_op_i
  , input wire dram_pkg::cache_ch_addr_s dma_pkt_addr_i
  , input wire logic [`DRAM_DATA_W-1:0]  dma_pkt_data_i
  , output logic                         dma_pkt_yumi_o

  , output logic                         rdata_v_o
  , output logic [`DRAM_DATA_W-1:0]      rdata_o
  , output dram_pkg::cache_ch_addr_s     rdone_addr_o
  , input wire logic                     rdata_yumi_i
);

  import dram_pkg::*;

  // producer to fifo
  logic                    req_v;
  dram_op_e                req_op;
  dram_ch_addr_s           req_addr;
  logic [`DRAM_DATA_W-1:0] req_data;
  logic                    req_ready;

  // fifo head to consumer
  logic                    head_v;
  dram_op_e                head_op;
  dram_ch_addr_s           head_addr;
  logic [`DRAM_DATA_W-1:0] head_data;
  logic                    head_deq;

  dma_to_dram_req producer (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.dma_pkt_v_i(dma_pkt_v_i)
    ,.dma_pkt_op_i(dma_pkt_op_i)
    ,.dma_pkt_addr_i(dma_pkt_addr_i)
    ,.dma_pkt_data_i(dma_pkt_data_i)
    ,.dma_pkt_yumi_o(dma_pkt_yumi_o)
    ,.req_v_o(req_v)
    ,.req_op_o(req_op)
    ,.req_addr_o(req_addr)
    ,.req_data_o(req_data)
    ,.req_ready_i(req_ready)
  );

  dram_req_fifo req_fifo (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.enq_v_i(req_v)
    ,.enq_op_i(req_op)
    ,.enq_addr_i(req_addr)
    ,.enq_data_i(req_data)
    ,.enq_ready_o(req_ready)
    ,.deq_v_o(head_v)
    ,.deq_op_o(head_op)
    ,.deq_addr_o(head_addr)
    ,.deq_data_o(head_data)
    ,.deq_i(head_deq)
  );

  dram_channel_mem channel_mem (
    .clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.req_v_i(head_v)
    ,.req_op_i(head_op)
    ,.req_addr_i(head_addr)
    ,.req_data_i(head_data)
    ,.req_deq_o(head_deq)
    ,.rdata_v_o(rdata_v_o)
    ,.rdata_o(rdata_o)
    ,.rdone_addr_o(rdone_addr_o)
    ,.rdata_yumi_i(rdata_yumi_i)
  );

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 10
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* test/tb_cache_dma_test_dram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "dram_defines.svh"

module tb_cache_dma_test_dram;

  import dram_pkg::*;

  localparam int NUM_PAIRS      = 40;
  localparam int NUM_MIX        = 60;
  // one read in the consumer, a full fifo, one in the producer slot
  localparam int STALL_CAP      = `REQ_FIFO_DEPTH + 2;
  localparam int STALL_TRY      = STALL_CAP + 2;
  localparam int NUM_PKTS       = 2 * NUM_PAIRS + NUM_MIX + STALL_TRY;
  localparam int TIMEOUT_CYCLES = NUM_PKTS * 20 + 200;
  localparam int WORDS          = 1 << `DRAM_WORD_ADDR_W;

  logic                    clk_i;
  logic                    arst_n_i;
  logic                    dma_pkt_v_i;
  dram_op_e                dma_pkt_op_i;
  cache_ch_addr_s          dma_pkt_addr_i;
  logic [`DRAM_DATA_W-1:0] dma_pkt_data_i;
  logic                    dma_pkt_yumi_o;
  logic                    rdata_v_o;
  logic [`DRAM_DATA_W-1:0] rdata_o;
  cache_ch_addr_s          rdone_addr_o;
  logic                    rdata_yumi_i;

  // reference model and expected reads in issue order
  logic [`DRAM_DATA_W-1:0] model_mem [WORDS];
  logic [`DRAM_DATA_W-1:0] exp_data  [NUM_PKTS];
  cache_ch_addr_s          exp_addr  [NUM_PKTS];
  cache_ch_addr_s          written   [$];
  int                      wr_idx        = 0;
  int                      rd_idx        = 0;
  int                      errors        = 0;
  int                      errors_seen   = 0;
  int                      tests_run     = 0;
  int                      stall_accepts = 0;
  logic                    stall_on      = 1'b0;
  logic                    stall_check   = 1'b0;
  logic [`DRAM_DATA_W-1:0] held_data;
  cache_ch_addr_s          held_addr;

  tb_clk_gen clk_gen (.clk_o(clk_i));

  cache_dma_test_dram dut (.*);

  always @(negedge clk_i) begin
    rdata_yumi_i <= !stall_on && ($urandom_range(0, 3) != 0);
  end

  always @(posedge clk_i) begin
    held_data <= rdata_o;
    held_addr <= rdone_addr_o;
    if (rdata_v_o && rdata_yumi_i) begin
      rd_idx <= rd_idx + 1;
    end
    if (stall_on && dma_pkt_yumi_o) begin
      stall_accepts <= stall_accepts + 1;
    end
  end

  reset_yumi_low: assert property (@(posedge clk_i)
    !arst_n_i || $rose(arst_n_i) |-> !dma_pkt_yumi_o)
    else begin
      errors++;
      $display("mismatch dma_pkt_yumi_o: got %h expected 0", dma_pkt_yumi_o);
    end

  reset_rdata_v_low: assert property (@(posedge clk_i)
    !arst_n_i || $rose(arst_n_i) |-> !rdata_v_o)
    else begin
      errors++;
      $display("mismatch rdata_v_o: got %h expected 0", rdata_v_o);
    end

  resp_expected: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rdata_v_o && rdata_yumi_i |-> rd_idx < wr_idx)
    else begin
      errors++;
      $display("read response returned with no read outstanding");
    end

  resp_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rdata_v_o && rdata_yumi_i && rd_idx < wr_idx |-> rdata_o == exp_data[rd_idx])
    else begin
      errors++;
      $display("mismatch rdata_o: got %h expected %h", rdata_o, exp_data[rd_idx]);
    end

  resp_addr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rdata_v_o && rdata_yumi_i && rd_idx < wr_idx |-> rdone_addr_o == exp_addr[rd_idx])
    else begin
      errors++;
      $display("mismatch rdone_addr_o: got %h expected %h", rdone_addr_o, exp_addr[rd_idx]);
    end

  resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rdata_v_o && !rdata_yumi_i |=>
      rdata_v_o && rdata_o == held_data && rdone_addr_o == held_addr)
    else begin
      errors++;
      $display("mismatch held response: rdata_v_o %h, rdata_o got %h expected %h, %s %h %h",
               rdata_v_o, rdata_o, held_data, "rdone_addr_o got/expected", rdone_addr_o,
               held_addr);
    end

  stall_no_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stall_on && stall_accepts >= STALL_CAP |-> !dma_pkt_yumi_o)
    else begin
      errors++;
      $display("producer accepted a packet with the whole path stalled");
    end

  stall_count: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stall_check |-> stall_accepts == STALL_CAP)
    else begin
      errors++;
      $display("mismatch stalled accepts: got %h expected %h", stall_accepts, STALL_CAP);
    end

  function automatic cache_ch_addr_s rand_addr();
    logic [`DRAM_ADDR_W-1:0] raw;
    raw = `DRAM_ADDR_W'($urandom);
    return raw;
  endfunction

  function automatic logic [`DRAM_WORD_ADDR_W-1:0] word_of(input cache_ch_addr_s a);
    return {a.bg, a.ba, a.ro, a.co};
  endfunction

  // called on a falling edge; max_wait of 0 waits for yumi without limit
  task automatic send_pkt(input dram_op_e op, input cache_ch_addr_s addr,
                          input logic [`DRAM_DATA_W-1:0] data, input int max_wait);
    int waited;
    waited = 0;
    dma_pkt_v_i    = 1'b1;
    dma_pkt_op_i   = op;
    dma_pkt_addr_i = addr;
    dma_pkt_data_i = data;
    #1;
    while (!dma_pkt_yumi_o && (max_wait == 0 || waited < max_wait)) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (dma_pkt_yumi_o && op == DRAM_WRITE) begin
      model_mem[word_of(addr)] = data;
    end else if (dma_pkt_yumi_o) begin
      exp_data[wr_idx] = model_mem[word_of(addr)];
      exp_addr[wr_idx] = addr;
      wr_idx++;
    end
    @(negedge clk_i);
    dma_pkt_v_i = 1'b0;
  endtask

  task automatic drain();
    while (rd_idx != wr_idx) begin
      @(negedge clk_i);
    end
    repeat (8) @(negedge clk_i);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - errors_seen);
    errors_seen = errors;
  endtask

  initial begin
    cache_ch_addr_s          addr;
    logic [`DRAM_DATA_W-1:0] data;
    void'($urandom(34406));
    arst_n_i       = 1'b0;
    dma_pkt_v_i    = 1'b0;
    dma_pkt_op_i   = DRAM_READ;
    dma_pkt_addr_i = '0;
    dma_pkt_data_i = '0;
    rdata_yumi_i   = 1'b0;
    repeat (4) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    finish_test("reset");

    // read back each word at a different byte offset
    for (int i = 0; i < NUM_PAIRS; i++) begin
      addr = rand_addr();
      data = $urandom;
      send_pkt(DRAM_WRITE, addr, data, 0);
      written.push_back(addr);
      addr.byte_offset = `DRAM_OFS_W'($urandom);
      send_pkt(DRAM_READ, addr, '0, 0);
    end
    drain();
    finish_test("write then read");

    for (int i = 0; i < NUM_MIX; i++) begin
      if ($urandom_range(0, 1) == 0) begin
        addr = rand_addr();
        data = $urandom;
        send_pkt(DRAM_WRITE, addr, data, 0);
        written.push_back(addr);
      end else begin
        addr = written[$urandom_range(0, written.size() - 1)];
        send_pkt(DRAM_READ, addr, '0, 0);
      end
    end
    drain();
    finish_test("mixed order");

    #1;
    stall_on = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < STALL_TRY; i++) begin
      addr = written[$urandom_range(0, written.size() - 1)];
      send_pkt(DRAM_READ, addr, '0, 10);
    end
    stall_check = 1'b1;
    @(negedge clk_i);
    stall_check = 1'b0;
    #1;
    stall_on = 1'b0;
    drain();
    finish_test("stall and drain");

    $display("tests %0d, reads checked %0d, errors %0d", tests_run, rd_idx, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * 10);
    $display("timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* cache_dma_test_dram.f */
+incdir+include
design/dram_pkg.sv
design/dma_to_dram_req.sv
design/dram_req_fifo.sv
design/dram_channel_mem.sv
design/cache_dma_test_dram.sv
test/tb_clk_gen.sv
test/tb_cache_dma_test_dram.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cache_dma_test_dram \
  -f cache_dma_test_dram.f \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
